// ==== project.f ====
source/pcie_phy_pkg.sv
source/lane_bus_if.sv
source/lane_order.sv
source/pack_data.sv
source/rx_block_fifo.sv
source/pcie_rx_pack_top.sv
testbench/tb_pcie_rx_pack.sv

// ==== run.sh ====
#!/bin/sh
# build and run the packer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_pcie_rx_pack \
  -f project.f \
  --Mdir obj_dir -o sim_tb

# the simulator exit code is masked by tee, the log decides
./obj_dir/sim_tb | tee sim.log

grep -q '\*\*\* PASSED \*\*\*' sim.log

// ==== source/lane_bus_if.sv ====
`timescale 1ns/1ps

// ordered lane stream from the lane stage to the packer
// no handshake, the pipe side never stalls
interface lane_bus_if #(
  parameter int NUM_LANES = 4
);

  // one byte per logical lane
  logic [NUM_LANES-1:0][7:0] data;
  // lane carries a byte this beat
  logic [NUM_LANES-1:0]      valid;
  // k flag per logical lane
  logic [NUM_LANES-1:0]      k;
  // active lane count, 1, 2 or 4
  logic [2:0]                active;

  // lane stage side
  modport src (
    output data,
    output valid,
    output k,
    output active
  );

  // packer side
  modport dst (
    input data,
    input valid,
    input k,
    input active
  );

endinterface

// ==== source/lane_order.sv ====
`timescale 1ns/1ps

module lane_order #(
  parameter int NUM_LANES = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      link_up_i,
  input  logic                      lane_reverse_i,
  input  logic [2:0]                num_lanes_i,
  input  logic [NUM_LANES-1:0][7:0] data_i,
  input  logic [NUM_LANES-1:0]      valid_i,
  input  logic [NUM_LANES-1:0]      k_i,
  lane_bus_if.src                   lanes_o
);

  logic [NUM_LANES-1:0][7:0] data_c;
  logic [NUM_LANES-1:0]      valid_c;
  logic [NUM_LANES-1:0]      k_c;
  int                        act_c;

  always_comb begin : remap_comb
    int src;
    // clamp so a bad count never indexes past the last lane
    act_c = (int'(num_lanes_i) > NUM_LANES) ? NUM_LANES : int'(num_lanes_i);
    for (int i = 0; i < NUM_LANES; i++) begin
      src = i;
      // reversal mirrors only the active lanes
      if (lane_reverse_i && (i < act_c)) begin
        src = act_c - 1 - i;
      end
      data_c[i]  = data_i[src];
      k_c[i]     = k_i[src];
      // lanes above the count and a down link carry nothing
      valid_c[i] = link_up_i && (i < act_c) && valid_i[src];
    end
  end

  // one register stage onto the bus
  always_ff @(posedge clk_i) begin : lane_seq
    if (rst_i) begin
      lanes_o.valid  <= '0;
      lanes_o.active <= '0;
    end else begin
      lanes_o.valid  <= valid_c;
      lanes_o.active <= 3'(act_c);
    end
    lanes_o.data <= data_c;
    lanes_o.k    <= k_c;
  end

  // only x1, x2 and x4 links are packed, never wider than the build
  a_lane_count: assert property (
    @(posedge clk_i) disable iff (rst_i)
    link_up_i |-> ((num_lanes_i inside {3'd1, 3'd2, 3'd4}) &&
                   (int'(num_lanes_i) <= NUM_LANES))
  );

endmodule

// ==== source/pack_data.sv ====
`timescale 1ns/1ps

module pack_data #(
  parameter int NUM_LANES = 4
) (
  input  logic               clk_i,
  input  logic               rst_i,
  lane_bus_if.dst            lanes_i,
  output logic               blk_wr_o,
  output pcie_phy_pkg::blk_t blk_o
);

  localparam int IDX_W = $clog2(pcie_phy_pkg::BLOCK_BYTES);
  localparam int OFF_W = $clog2(pcie_phy_pkg::BLOCK_BYTES + 1);
  localparam logic [OFF_W-1:0] OFF_FULL = OFF_W'(pcie_phy_pkg::BLOCK_BYTES);

  pcie_phy_pkg::pack_st_e state_r;
  pcie_phy_pkg::pack_st_e state_c;

  // accumulator and the closed block waiting on the write port
  pcie_phy_pkg::blk_t acc_r;
  pcie_phy_pkg::blk_t acc_c;
  pcie_phy_pkg::blk_t blk_r;

  // next free byte position in the accumulator
  logic [OFF_W-1:0] off_r;
  logic [OFF_W-1:0] off_c;
  logic [IDX_W-1:0] idx_c;
  logic             close_c;
  logic             is_end_c;

  always_comb begin : pack_comb
    // only a fill state keeps bytes, idle and flush start empty
    if (state_r == pcie_phy_pkg::PK_FILL) begin
      acc_c = acc_r;
      off_c = off_r;
    end else begin
      acc_c = '0;
      off_c = '0;
    end
    close_c  = 1'b0;
    is_end_c = 1'b0;
    idx_c    = '0;

    if (|lanes_i.valid) begin
      // lane 0 first, valid lanes are packed back to back
      for (int i = 0; i < NUM_LANES; i++) begin
        if (!close_c && (i < int'(lanes_i.active)) && lanes_i.valid[i]) begin
          idx_c                   = off_c[IDX_W-1:0];
          acc_c.data[idx_c]       = lanes_i.data[i];
          acc_c.byte_valid[idx_c] = 1'b1;
          acc_c.k_mask[idx_c]     = lanes_i.k[i];
          off_c                   = off_c + 1'b1;
          is_end_c = lanes_i.k[i] && (lanes_i.data[i] == pcie_phy_pkg::END_SYM);
          // END closes the block, the END byte itself stays in it
          if (is_end_c) begin
            acc_c.ended = 1'b1;
            close_c     = 1'b1;
          end else if (off_c == OFF_FULL) begin
            close_c = 1'b1;
          end
        end
      end
    end

    // bytes after the closing byte in the same beat are dropped
    // with a steady count of 1, 2 or 4 a full block ends on a beat edge
    if (close_c) begin
      state_c = pcie_phy_pkg::PK_FLUSH;
      off_c   = '0;
    end else if (off_c != '0) begin
      state_c = pcie_phy_pkg::PK_FILL;
    end else begin
      state_c = pcie_phy_pkg::PK_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin : pack_seq
    if (rst_i) begin
      state_r <= pcie_phy_pkg::PK_IDLE;
      off_r   <= '0;
    end else begin
      state_r <= state_c;
      off_r   <= off_c;
    end
    acc_r <= acc_c;
    // hold the closed block for its write cycle
    if (close_c) begin
      blk_r <= acc_c;
    end
  end

  // write strobe is the flush state, one cycle after the closing beat
  assign blk_wr_o = (state_r == pcie_phy_pkg::PK_FLUSH);
  assign blk_o    = blk_r;

  // offset wraps to zero on every close
  a_off_bound: assert property (
    @(posedge clk_i) disable iff (rst_i)
    off_r < OFF_FULL
  );

  // lane stage masks everything above the active count
  a_valid_in_range: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (lanes_i.valid >> lanes_i.active) == '0
  );

endmodule

// ==== source/pcie_phy_pkg.sv ====
package pcie_phy_pkg;

  // bytes per packed block toward the link layer
  localparam int BLOCK_BYTES = 16;

  // END k-symbol, 8b/10b K29.7
  localparam logic [7:0] END_SYM = 8'hFD;

  // default block depth of the rx buffer
  localparam int FIFO_DEPTH_DEFAULT = 4;

  // one packed block
  // byte 0 sits in the low bits of each field
  typedef struct packed {
    // payload bytes in logical order
    logic [BLOCK_BYTES-1:0][7:0] data;
    // set for every byte position that was filled
    logic [BLOCK_BYTES-1:0]      byte_valid;
    // k flag per byte position
    logic [BLOCK_BYTES-1:0]      k_mask;
    // block was closed by END rather than by full
    logic                        ended;
  } blk_t;

  // packer states
  // idle: accumulator empty
  // fill: partial block held
  // flush: closed block on the write port this cycle
  typedef enum logic [1:0] {
    PK_IDLE,
    PK_FILL,
    PK_FLUSH
  } pack_st_e;

endpackage

// ==== source/pcie_rx_pack_top.sv ====
`timescale 1ns/1ps

module pcie_rx_pack_top #(
  parameter int NUM_LANES  = 4,
  parameter int FIFO_DEPTH = pcie_phy_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         link_up_i,
  input  logic                                         lane_reverse_i,
  input  logic [2:0]                                   num_lanes_i,
  input  logic [NUM_LANES-1:0][7:0]                    data_i,
  input  logic [NUM_LANES-1:0]                         valid_i,
  input  logic [NUM_LANES-1:0]                         k_i,
  input  logic                                         credit_i,
  output logic                                         blk_valid_o,
  output logic [pcie_phy_pkg::BLOCK_BYTES-1:0][7:0]    blk_data_o,
  output logic [pcie_phy_pkg::BLOCK_BYTES-1:0]         blk_byte_valid_o,
  output logic [pcie_phy_pkg::BLOCK_BYTES-1:0]         blk_k_mask_o,
  output logic                                         blk_ended_o,
  output logic                                         overflow_o
);

  pcie_phy_pkg::blk_t wr_blk;
  pcie_phy_pkg::blk_t rd_blk;
  logic               blk_wr;

  // ordered lanes between lane stage and packer
  lane_bus_if #(.NUM_LANES(NUM_LANES)) lane_bus ();

  lane_order #(.NUM_LANES(NUM_LANES)) u_lane_order (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .link_up_i      (link_up_i),
    .lane_reverse_i (lane_reverse_i),
    .num_lanes_i    (num_lanes_i),
    .data_i         (data_i),
    .valid_i        (valid_i),
    .k_i            (k_i),
    .lanes_o        (lane_bus.src)
  );

  pack_data #(.NUM_LANES(NUM_LANES)) u_pack_data (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .lanes_i  (lane_bus.dst),
    .blk_wr_o (blk_wr),
    .blk_o    (wr_blk)
  );

  rx_block_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_block_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .blk_wr_i    (blk_wr),
    .blk_i       (wr_blk),
    .credit_i    (credit_i),
    .blk_valid_o (blk_valid_o),
    .blk_o       (rd_blk),
    .overflow_o  (overflow_o)
  );

  // block fields out as flat ports for the link layer
  assign blk_data_o       = rd_blk.data;
  assign blk_byte_valid_o = rd_blk.byte_valid;
  assign blk_k_mask_o     = rd_blk.k_mask;
  assign blk_ended_o      = rd_blk.ended;

endmodule

// ==== source/rx_block_fifo.sv ====
`timescale 1ns/1ps

module rx_block_fifo #(
  parameter int FIFO_DEPTH = pcie_phy_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               blk_wr_i,
  input  pcie_phy_pkg::blk_t blk_i,
  input  logic               credit_i,
  output logic               blk_valid_o,
  output pcie_phy_pkg::blk_t blk_o,
  output logic               overflow_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRED_W = 8;
  localparam logic [CRED_W-1:0] MAX_CREDITS = '1;

  pcie_phy_pkg::blk_t mem [FIFO_DEPTH];
  pcie_phy_pkg::blk_t blk_r;

  logic [PTR_W-1:0]  wr_ptr_r;
  logic [PTR_W-1:0]  rd_ptr_r;
  logic [CNT_W-1:0]  count_r;
  logic [CRED_W-1:0] cred_r;
  logic              blk_valid_r;
  logic              overflow_r;
  logic              full;
  logic              push;
  logic              spend;

  // circular pointer step, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    next_ptr = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full  = (count_r == CNT_W'(FIFO_DEPTH));
  // one block out per cycle while a block and a credit are both held
  assign spend = (count_r != '0) && (cred_r != '0);
  // a full buffer still takes the write if a slot frees this cycle
  assign push  = blk_wr_i && (!full || spend);

  always_ff @(posedge clk_i) begin : fifo_ctrl_seq
    if (rst_i) begin
      wr_ptr_r    <= '0;
      rd_ptr_r    <= '0;
      count_r     <= '0;
      cred_r      <= '0;
      blk_valid_r <= 1'b0;
      overflow_r  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (spend) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      count_r     <= count_r + CNT_W'(push) - CNT_W'(spend);
      cred_r      <= cred_r + CRED_W'(credit_i) - CRED_W'(spend);
      blk_valid_r <= spend;
      // sticky until reset, block is lost
      if (blk_wr_i && !push) begin
        overflow_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : fifo_data_seq
    if (push) begin
      mem[wr_ptr_r] <= blk_i;
    end
    if (spend) begin
      blk_r <= mem[rd_ptr_r];
    end
  end

  assign blk_valid_o = blk_valid_r;
  assign blk_o       = blk_r;
  assign overflow_o  = overflow_r;

  // empty counter must not wrap upward on a spend
  a_cred_underflow: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (cred_r == '0) |=> (cred_r <= CRED_W'(1))
  );

  // link layer never returns more credits than the counter holds
  a_cred_bound: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (cred_r == MAX_CREDITS) |=> (cred_r != '0)
  );

endmodule

// ==== testbench/tb_pcie_rx_pack.sv ====
`timescale 1ns/1ps

module tb_pcie_rx_pack;

  localparam int NUM_LANES  = 4;
  localparam int FIFO_DEPTH = pcie_phy_pkg::FIFO_DEPTH_DEFAULT;
  localparam int LW         = $clog2(NUM_LANES);
  localparam int IDX_W      = $clog2(pcie_phy_pkg::BLOCK_BYTES);
  localparam int WAIT_LIMIT = 200;

  logic                                      clk_i;
  logic                                      rst_i;
  logic                                      link_up_i;
  logic                                      lane_reverse_i;
  logic [2:0]                                num_lanes_i;
  logic [NUM_LANES-1:0][7:0]                 data_i;
  logic [NUM_LANES-1:0]                      valid_i;
  logic [NUM_LANES-1:0]                      k_i;
  logic                                      credit_i;
  logic                                      blk_valid_o;
  logic [pcie_phy_pkg::BLOCK_BYTES-1:0][7:0] blk_data_o;
  logic [pcie_phy_pkg::BLOCK_BYTES-1:0]      blk_byte_valid_o;
  logic [pcie_phy_pkg::BLOCK_BYTES-1:0]      blk_k_mask_o;
  logic                                      blk_ended_o;
  logic                                      overflow_o;

  // reference model state, config mirrors what the DUT sees
  pcie_phy_pkg::blk_t exp_q[$];
  pcie_phy_pkg::blk_t acc_model;
  int                 acc_off;
  bit                 cfg_up;
  bit                 cfg_rev;
  int                 cfg_lanes;
  int                 rx_count;
  integer             seed = 79;

  pcie_rx_pack_top #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .link_up_i        (link_up_i),
    .lane_reverse_i   (lane_reverse_i),
    .num_lanes_i      (num_lanes_i),
    .data_i           (data_i),
    .valid_i          (valid_i),
    .k_i              (k_i),
    .credit_i         (credit_i),
    .blk_valid_o      (blk_valid_o),
    .blk_data_o       (blk_data_o),
    .blk_byte_valid_o (blk_byte_valid_o),
    .blk_k_mask_o     (blk_k_mask_o),
    .blk_ended_o      (blk_ended_o),
    .overflow_o       (overflow_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [127:0] exp,
                             input logic [127:0] got);
    $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, exp, got);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_error(name, 128'(exp), 128'(got));
    end
  endtask

  task automatic check_blk(input pcie_phy_pkg::blk_t got, input pcie_phy_pkg::blk_t exp);
    if (got.data !== exp.data) begin
      value_error("blk_data_o", exp.data, got.data);
    end
    if (got.byte_valid !== exp.byte_valid) begin
      value_error("blk_byte_valid_o", 128'(exp.byte_valid), 128'(got.byte_valid));
    end
    if (got.k_mask !== exp.k_mask) begin
      value_error("blk_k_mask_o", 128'(exp.k_mask), 128'(got.k_mask));
    end
    check_bit("blk_ended_o", got.ended, exp.ended);
  endtask

  // random payload byte, END only where a test puts it
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = 8'($random(seed));
    if (b == pcie_phy_pkg::END_SYM) begin
      b = 8'h00;
    end
    return b;
  endfunction

  // reference packer: logical order per beat, then byte packing
  function automatic void model_beat(input logic [NUM_LANES-1:0][7:0] d,
                                     input logic [NUM_LANES-1:0] v,
                                     input logic [NUM_LANES-1:0] kk);
    int               src;
    logic [IDX_W-1:0] idx;
    logic [7:0]       byte_v;
    logic             k_v;
    bit               closed;
    closed = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      // mirror only inside the active lanes
      src    = (cfg_rev && (i < cfg_lanes)) ? cfg_lanes - 1 - i : i;
      byte_v = d[LW'(src)];
      k_v    = kk[LW'(src)];
      // down link and lanes above the count carry nothing
      if (cfg_up && (i < cfg_lanes) && v[LW'(src)] && !closed) begin
        idx                       = IDX_W'(acc_off);
        acc_model.data[idx]       = byte_v;
        acc_model.byte_valid[idx] = 1'b1;
        acc_model.k_mask[idx]     = k_v;
        acc_off++;
        if (k_v && (byte_v == pcie_phy_pkg::END_SYM)) begin
          acc_model.ended = 1'b1;
          closed          = 1'b1;
        end else if (acc_off == pcie_phy_pkg::BLOCK_BYTES) begin
          closed = 1'b1;
        end
      end
    end
    if (closed) begin
      exp_q.push_back(acc_model);
      acc_model = '0;
      acc_off   = 0;
    end
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    rst_i    <= 1'b1;
    valid_i  <= '0;
    credit_i <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
    end
    rst_i <= 1'b0;
    acc_model = '0;
    acc_off   = 0;
    rx_count  = 0;
    exp_q.delete();
  endtask

  task automatic set_cfg(input bit up, input bit rev, input int lanes);
    @(posedge clk_i);
    link_up_i      <= up;
    lane_reverse_i <= rev;
    num_lanes_i    <= 3'(lanes);
    cfg_up    = up;
    cfg_rev   = rev;
    cfg_lanes = lanes;
  endtask

  task automatic drive_beat(input logic [NUM_LANES-1:0][7:0] d,
                            input logic [NUM_LANES-1:0] v,
                            input logic [NUM_LANES-1:0] kk);
    @(posedge clk_i);
    data_i  <= d;
    valid_i <= v;
    k_i     <= kk;
    model_beat(d, v, kk);
  endtask

  // every lane valid, masking is left to the DUT
  task automatic send_random(input int nbeats);
    logic [NUM_LANES-1:0][7:0] d;
    d = '0;
    for (int b = 0; b < nbeats; b++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        d = {d[NUM_LANES-2:0], rand_byte()};
      end
      drive_beat(d, '1, '0);
    end
    drive_beat('0, '0, '0);
  endtask

  task automatic give_credits(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      credit_i <= 1'b1;
    end
    @(posedge clk_i);
    credit_i <= 1'b0;
  endtask

  task automatic wait_blocks(input int target);
    int cycles;
    cycles = 0;
    while (rx_count < target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout: %0d of %0d blocks arrived on blk_valid_o", rx_count, target);
        abort_run();
      end
    end
  endtask

  task automatic wait_overflow();
    int cycles;
    cycles = 0;
    while (overflow_o !== 1'b1) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout: overflow_o never rose after the buffer filled");
        abort_run();
      end
    end
  endtask

  // no block may leave during this window
  task automatic expect_idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      check_bit("blk_valid_o", blk_valid_o, 1'b0);
    end
  endtask

  // outputs are registered, sampled mid cycle
  always @(negedge clk_i) begin : compare_proc
    pcie_phy_pkg::blk_t got;
    pcie_phy_pkg::blk_t exp;
    if (!rst_i && blk_valid_o) begin
      got.data       = blk_data_o;
      got.byte_valid = blk_byte_valid_o;
      got.k_mask     = blk_k_mask_o;
      got.ended      = blk_ended_o;
      if (exp_q.size() == 0) begin
        $display("block on blk_valid_o while none was expected");
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        check_blk(got, exp);
        rx_count++;
      end
    end
  end

  initial begin : stim_proc
    logic [NUM_LANES-1:0][7:0] d;
    rst_i          <= 1'b1;
    link_up_i      <= 1'b0;
    lane_reverse_i <= 1'b0;
    num_lanes_i    <= 3'd4;
    data_i         <= '0;
    valid_i        <= '0;
    k_i            <= '0;
    credit_i       <= 1'b0;
    apply_reset();
    @(negedge clk_i);
    check_bit("blk_valid_o", blk_valid_o, 1'b0);
    check_bit("overflow_o", overflow_o, 1'b0);

    // x4 full block
    set_cfg(1'b1, 1'b0, 4);
    give_credits(1);
    send_random(4);
    wait_blocks(1);

    // x2, END as the sixth byte
    set_cfg(1'b1, 1'b0, 2);
    give_credits(1);
    send_random(2);
    d = {rand_byte(), rand_byte(), pcie_phy_pkg::END_SYM, rand_byte()};
    drive_beat(d, '1, 4'b0010);
    drive_beat('0, '0, '0);
    wait_blocks(2);

    // reversal on x4 then x2
    set_cfg(1'b1, 1'b1, 4);
    give_credits(1);
    send_random(4);
    wait_blocks(3);
    set_cfg(1'b1, 1'b1, 2);
    give_credits(1);
    send_random(8);
    wait_blocks(4);

    // link down drops everything even with a credit held
    set_cfg(1'b0, 1'b0, 4);
    give_credits(1);
    send_random(6);
    expect_idle(20);
    set_cfg(1'b1, 1'b0, 1);
    send_random(16);
    wait_blocks(5);

    // three blocks held back until credits return
    set_cfg(1'b1, 1'b0, 4);
    send_random(12);
    expect_idle(20);
    give_credits(2);
    wait_blocks(7);
    expect_idle(20);
    give_credits(1);
    wait_blocks(8);

    // one block past the buffer depth
    apply_reset();
    set_cfg(1'b1, 1'b0, 4);
    send_random(4 * FIFO_DEPTH);
    expect_idle(10);
    check_bit("overflow_o", overflow_o, 1'b0);
    send_random(4);
    wait_overflow();
    // last block lost at the full buffer
    void'(exp_q.pop_back());
    give_credits(FIFO_DEPTH + 1);
    wait_blocks(FIFO_DEPTH);
    expect_idle(20);
    check_bit("overflow_o", overflow_o, 1'b1);

    if ((exp_q.size() == 0) && (rx_count == FIFO_DEPTH)) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("%0d expected blocks never arrived", exp_q.size());
      $display("*** FAILED ***");
      $fatal(1, "run ended with blocks missing");
    end
  end

endmodule
